// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_finish_show -f finish_show.f

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_finish_show \
		-f finish_show.f -o sim_finish_show
	./obj_dir/sim_finish_show | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: color_ramp.sv
`timescale 1ns/1ns
`default_nettype none

module color_ramp (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         tick,
    input  logic                         first_tick,
    input  finish_show_pkg::script_step_t entry,
    output finish_show_pkg::rgb_level_t   level,
    output logic                         sound_en,
    output finish_show_pkg::note_t        note_sel
);

    localparam int LEVEL_W = finish_show_pkg::LEVEL_W;
    localparam logic [LEVEL_W-1:0] LEVEL_MAX = '1;

    function automatic logic [LEVEL_W-1:0] ramp_level(
        input logic [LEVEL_W-1:0]     cur,
        input finish_show_pkg::ramp_t dir
    );
        case (dir)
            finish_show_pkg::RAMP_UP:   ramp_level = cur + 1'b1;
            finish_show_pkg::RAMP_DOWN: ramp_level = cur - 1'b1;
            default:                    ramp_level = cur;
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            level    <= '0;
            sound_en <= 1'b0;
            note_sel <= finish_show_pkg::NOTE_C;
        end else begin
            if (tick) begin
                level.red   <= ramp_level(level.red, entry.red_dir);
                level.green <= ramp_level(level.green, entry.green_dir);
                level.blue  <= ramp_level(level.blue, entry.blue_dir);
            end
            if (first_tick && entry.sound_set) begin
                sound_en <= 1'b1;
            end
            if (first_tick && entry.sound_clr) begin
                sound_en <= 1'b0;
            end
            if (tick && entry.sound_set) begin
                note_sel <= entry.note;     // Follows the row on a tick
            end
        end
    end

    property no_wrap(logic [LEVEL_W-1:0] lv, finish_show_pkg::ramp_t dir);
        @(posedge clk) disable iff (reset)
        tick |-> !((dir == finish_show_pkg::RAMP_DOWN && lv == '0) ||
                   (dir == finish_show_pkg::RAMP_UP && lv == LEVEL_MAX));
    endproperty

    red_no_wrap:   assert property (no_wrap(level.red, entry.red_dir));
    green_no_wrap: assert property (no_wrap(level.green, entry.green_dir));
    blue_no_wrap:  assert property (no_wrap(level.blue, entry.blue_dir));

endmodule

`default_nettype wire

// File: finish_show.f
finish_show_pkg.sv
show_sequencer.sv
show_script.sv
color_ramp.sv
led_pwm.sv
finish_show.sv
show_checker.sv
tb_finish_show.sv

// File: finish_show.sv
`timescale 1ns/1ns
`default_nettype none

module finish_show #(
    parameter int TICK_DIV   = 20000,
    parameter int RAMP_TICKS = 127
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  show_en,
    output logic                  red_up,
    output logic                  red_down,
    output logic                  green_up,
    output logic                  green_down,
    output logic                  blue_up,
    output logic                  blue_down,
    output logic                  sound_en,
    output finish_show_pkg::note_t note_sel,
    output logic                  show_done
);

    logic [finish_show_pkg::STEP_W-1:0] step;
    logic                               tick;
    logic                               first_tick;
    finish_show_pkg::script_step_t      entry;
    finish_show_pkg::rgb_level_t        level;

    show_sequencer #(
        .TICK_DIV   (TICK_DIV),
        .RAMP_TICKS (RAMP_TICKS)
    ) u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .show_en    (show_en),
        .tick       (tick),
        .first_tick (first_tick),
        .show_done  (show_done),
        .step       (step)
    );

    show_script u_script (
        .step  (step),
        .entry (entry)
    );

    color_ramp u_ramp (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .first_tick (first_tick),
        .entry      (entry),
        .level      (level),
        .sound_en   (sound_en),
        .note_sel   (note_sel)
    );

    led_pwm u_pwm (
        .clk        (clk),
        .reset      (reset),
        .level      (level),
        .red_up     (red_up),
        .red_down   (red_down),
        .green_up   (green_up),
        .green_down (green_down),
        .blue_up    (blue_up),
        .blue_down  (blue_down)
    );

endmodule

`default_nettype wire

// File: finish_show_pkg.sv
`default_nettype none

package finish_show_pkg;

    localparam int LEVEL_W   = 8;   // PWM level and counter width
    localparam int STEP_W    = 5;
    localparam int LAST_STEP = 30;

    typedef enum logic [3:0] {
        NOTE_C    = 4'd0,
        NOTE_D    = 4'd1,
        NOTE_E    = 4'd2,
        NOTE_F    = 4'd3,
        NOTE_G    = 4'd4,
        NOTE_A    = 4'd5,
        NOTE_B    = 4'd6,
        NOTE_C_HI = 4'd7
    } note_t;

    typedef enum logic [1:0] {
        RAMP_HOLD = 2'd0,
        RAMP_UP   = 2'd1,
        RAMP_DOWN = 2'd2
    } ramp_t;

    // One row of the fade script
    typedef struct packed {
        ramp_t red_dir;
        ramp_t green_dir;
        ramp_t blue_dir;
        logic  sound_set;   // Start tone on first tick
        logic  sound_clr;   // Stop tone on first tick
        note_t note;
    } script_step_t;

    typedef struct packed {
        logic [LEVEL_W-1:0] red;
        logic [LEVEL_W-1:0] green;
        logic [LEVEL_W-1:0] blue;
    } rgb_level_t;

endpackage

`default_nettype wire

// File: led_pwm.sv
`timescale 1ns/1ns
`default_nettype none

module led_pwm (
    input  logic                       clk,
    input  logic                       reset,
    input  finish_show_pkg::rgb_level_t level,
    output logic                       red_up,
    output logic                       red_down,
    output logic                       green_up,
    output logic                       green_down,
    output logic                       blue_up,
    output logic                       blue_down
);

    logic [finish_show_pkg::LEVEL_W-1:0] pwm_cnt;   // Wraps every 256 cycles
    logic red_on;
    logic green_on;
    logic blue_on;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    assign red_on   = (pwm_cnt < level.red);
    assign green_on = (pwm_cnt < level.green);
    assign blue_on  = (pwm_cnt < level.blue);

    // Both LEDs show the same colour
    assign red_up     = red_on;
    assign red_down   = red_on;
    assign green_up   = green_on;
    assign green_down = green_on;
    assign blue_up    = blue_on;
    assign blue_down  = blue_on;

endmodule

`default_nettype wire

// File: show_checker.sv
`timescale 1ns/1ns
`default_nettype none

module show_checker (
    input  logic                        clk,
    input  logic                        red_up,
    input  logic                        red_down,
    input  logic                        green_up,
    input  logic                        green_down,
    input  logic                        blue_up,
    input  logic                        blue_down,
    input  logic                        sound_en,
    input  finish_show_pkg::note_t      note_sel,
    input  logic                        show_done,
    input  logic                        level_req,     // Held high for one 256-cycle window
    input  finish_show_pkg::rgb_level_t exp_level,
    input  int                          exp_done,
    input  logic                        sound_req,     // Compare sound on this cycle
    input  logic                        exp_sound,
    input  finish_show_pkg::note_t      exp_note,
    output logic                        level_ack,
    output int                          level_errors,
    output int                          sound_errors,
    output int                          done_errors
);

    localparam int WINDOW = 256;    // One full PWM period

    int   hi_red;
    int   hi_green;
    int   hi_blue;
    int   win_cnt;
    int   done_seen;
    logic done_prev;

    task automatic compare_count(input string name, input int got, input int want);
        if (got != want) begin
            level_errors++;
            $display("error %0t ns: %s high for %0d of %0d cycles, expected %0d",
                     $time, name, got, WINDOW, want);
        end
    endtask

    initial begin
        level_ack    = 1'b0;
        level_errors = 0;
        sound_errors = 0;
        done_errors  = 0;
        hi_red       = 0;
        hi_green     = 0;
        hi_blue      = 0;
        win_cnt      = 0;
        done_seen    = 0;
        done_prev    = 1'b0;
    end

    // Outputs settle after the rising edge, so sample mid-cycle
    always @(negedge clk) begin
        if (red_up != red_down || green_up != green_down || blue_up != blue_down) begin
            level_errors++;
            $display("error %0t ns: up and down outputs of one colour disagree", $time);
        end
        if (show_done && done_prev) begin
            done_errors++;
            $display("error %0t ns: show_done high for more than one cycle", $time);
        end
        if (show_done) begin
            done_seen++;
        end
        done_prev = show_done;
        if (sound_req && (sound_en != exp_sound || note_sel != exp_note)) begin
            sound_errors++;
            $display("error %0t ns: sound_en %b note %0d, expected %b note %0d",
                     $time, sound_en, note_sel, exp_sound, exp_note);
        end
        if (level_req && !level_ack) begin
            hi_red   = hi_red + int'(red_up);
            hi_green = hi_green + int'(green_up);
            hi_blue  = hi_blue + int'(blue_up);
            win_cnt++;
            if (win_cnt == WINDOW) begin
                compare_count("red", hi_red, int'(exp_level.red));
                compare_count("green", hi_green, int'(exp_level.green));
                compare_count("blue", hi_blue, int'(exp_level.blue));
                if (done_seen != exp_done) begin
                    done_errors++;
                    $display("error %0t ns: %0d show_done pulses so far, expected %0d",
                             $time, done_seen, exp_done);
                end
                level_ack = 1'b1;
            end
        end else if (!level_req) begin
            level_ack = 1'b0;
            hi_red    = 0;
            hi_green  = 0;
            hi_blue   = 0;
            win_cnt   = 0;
        end
    end

endmodule

`default_nettype wire

// File: show_script.sv
`timescale 1ns/1ns
`default_nettype none

module show_script (
    input  logic [finish_show_pkg::STEP_W-1:0] step,
    output finish_show_pkg::script_step_t      entry
);

    localparam finish_show_pkg::ramp_t HO = finish_show_pkg::RAMP_HOLD;
    localparam finish_show_pkg::ramp_t UP = finish_show_pkg::RAMP_UP;
    localparam finish_show_pkg::ramp_t DN = finish_show_pkg::RAMP_DOWN;

    // Columns are red, green, blue, set, clear, note.
    // Every channel returns to zero by the last step and never exceeds one full ramp.
    always_comb begin
        case (step)
            5'd1:    entry = '{UP, HO, HO, 1'b1, 1'b0, finish_show_pkg::NOTE_C};
            5'd2:    entry = '{DN, HO, HO, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd3:    entry = '{HO, UP, HO, 1'b1, 1'b0, finish_show_pkg::NOTE_C};
            5'd4:    entry = '{HO, DN, HO, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd5:    entry = '{HO, HO, UP, 1'b1, 1'b0, finish_show_pkg::NOTE_G};
            5'd6:    entry = '{HO, HO, DN, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd7:    entry = '{HO, UP, UP, 1'b1, 1'b0, finish_show_pkg::NOTE_G};  // Cyan
            5'd8:    entry = '{HO, DN, DN, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd9:    entry = '{UP, HO, UP, 1'b1, 1'b0, finish_show_pkg::NOTE_A};  // Magenta
            5'd10:   entry = '{DN, HO, DN, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd11:   entry = '{UP, UP, HO, 1'b1, 1'b0, finish_show_pkg::NOTE_A};  // Yellow
            5'd12:   entry = '{DN, DN, HO, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd13:   entry = '{UP, HO, HO, 1'b1, 1'b0, finish_show_pkg::NOTE_G};
            5'd14:   entry = '{DN, UP, HO, 1'b0, 1'b0, finish_show_pkg::NOTE_C};  // Tone carries on
            5'd15:   entry = '{HO, DN, HO, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd16:   entry = '{HO, HO, UP, 1'b1, 1'b0, finish_show_pkg::NOTE_F};
            5'd17:   entry = '{HO, UP, DN, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd18:   entry = '{UP, DN, HO, 1'b1, 1'b0, finish_show_pkg::NOTE_F};
            5'd19:   entry = '{DN, HO, UP, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd20:   entry = '{HO, UP, DN, 1'b1, 1'b0, finish_show_pkg::NOTE_E};
            5'd21:   entry = '{UP, HO, UP, 1'b0, 1'b1, finish_show_pkg::NOTE_C};  // White
            5'd22:   entry = '{DN, HO, HO, 1'b1, 1'b0, finish_show_pkg::NOTE_E};
            5'd23:   entry = '{HO, HO, DN, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd24:   entry = '{UP, DN, HO, 1'b1, 1'b0, finish_show_pkg::NOTE_D};
            5'd25:   entry = '{DN, HO, UP, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            5'd26:   entry = '{UP, HO, HO, 1'b1, 1'b0, finish_show_pkg::NOTE_D};
            5'd27:   entry = '{HO, UP, HO, 1'b0, 1'b1, finish_show_pkg::NOTE_C};  // White again
            5'd28:   entry = '{HO, HO, DN, 1'b1, 1'b0, finish_show_pkg::NOTE_C};
            5'd29:   entry = '{DN, HO, HO, 1'b0, 1'b0, finish_show_pkg::NOTE_C};
            5'd30:   entry = '{HO, DN, HO, 1'b0, 1'b1, finish_show_pkg::NOTE_C};
            default: entry = '{HO, HO, HO, 1'b0, 1'b0, finish_show_pkg::NOTE_C};
        endcase
    end

endmodule

`default_nettype wire

// File: show_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module show_sequencer #(
    parameter int TICK_DIV   = 20000,
    parameter int RAMP_TICKS = 127
) (
    input  logic clk,
    input  logic reset,
    input  logic show_en,
    output logic tick,
    output logic first_tick,
    output logic show_done,
    output logic [finish_show_pkg::STEP_W-1:0] step
);

    localparam int DIV_W  = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam int TICK_W = (RAMP_TICKS > 1) ? $clog2(RAMP_TICKS) : 1;
    localparam int STEP_W = finish_show_pkg::STEP_W;

    localparam logic [DIV_W-1:0]  DIV_LAST   = DIV_W'(TICK_DIV - 1);
    localparam logic [TICK_W-1:0] TICK_LAST  = TICK_W'(RAMP_TICKS - 1);
    localparam logic [STEP_W-1:0] FIRST_STEP = STEP_W'(1);
    localparam logic [STEP_W-1:0] FINAL_STEP = STEP_W'(finish_show_pkg::LAST_STEP);

    logic [DIV_W-1:0]  div_cnt;
    logic [TICK_W-1:0] tick_cnt;    // Ticks done within current step
    logic              step_end;

    assign tick       = show_en && (div_cnt == DIV_LAST);
    assign first_tick = tick && (tick_cnt == '0);
    assign step_end   = tick && (tick_cnt == TICK_LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt   <= '0;
            tick_cnt  <= '0;
            step      <= FIRST_STEP;
            show_done <= 1'b0;
        end else begin
            show_done <= 1'b0;
            if (show_en) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (step_end) begin
                    tick_cnt <= '0;
                    if (step == FINAL_STEP) begin
                        step      <= FIRST_STEP;    // Replay the script
                        show_done <= 1'b1;
                    end else begin
                        step <= step + 1'b1;
                    end
                end else if (tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

    step_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (step >= FIRST_STEP) && (step <= FINAL_STEP)
    );

endmodule

`default_nettype wire

// File: tb_finish_show.sv
`timescale 1ns/1ns
`default_nettype none

module tb_finish_show;

    localparam int TICK_DIV    = 4;
    localparam int RAMP_TICKS  = 127;
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int WINDOW      = 256;
    localparam int LEVEL_W     = finish_show_pkg::LEVEL_W;
    localparam int SCRIPT_LEN  = finish_show_pkg::LAST_STEP;
    localparam int STEP_CYCLES = RAMP_TICKS * TICK_DIV;
    localparam int MARGIN      = (SCRIPT_LEN + 4) * (WINDOW + 64);  // Pauses and windows
    localparam int WATCHDOG_CYCLES = 2 * (SCRIPT_LEN * STEP_CYCLES + MARGIN);

    localparam logic [1:0] ACT_NONE = 2'd0;
    localparam logic [1:0] ACT_SET  = 2'd1;
    localparam logic [1:0] ACT_CLR  = 2'd2;

    typedef struct packed {
        finish_show_pkg::note_t note;    // note_sel after the first tick
        logic [1:0]             action;
        logic [LEVEL_W-1:0]     red;     // Levels at the end of the step
        logic [LEVEL_W-1:0]     green;
        logic [LEVEL_W-1:0]     blue;
        logic                   pause;   // Drop show_en partway through
    } row_t;

    localparam row_t SCRIPT_TAB [SCRIPT_LEN] = '{
        '{finish_show_pkg::NOTE_C, ACT_SET,  8'd127, 8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_C, ACT_CLR,  8'd0,   8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_C, ACT_SET,  8'd0,   8'd127, 8'd0,   1'b0},
        '{finish_show_pkg::NOTE_C, ACT_CLR,  8'd0,   8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_G, ACT_SET,  8'd0,   8'd0,   8'd127, 1'b0},
        '{finish_show_pkg::NOTE_G, ACT_CLR,  8'd0,   8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_G, ACT_SET,  8'd0,   8'd127, 8'd127, 1'b0},
        '{finish_show_pkg::NOTE_G, ACT_CLR,  8'd0,   8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_A, ACT_SET,  8'd127, 8'd0,   8'd127, 1'b1},
        '{finish_show_pkg::NOTE_A, ACT_CLR,  8'd0,   8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_A, ACT_SET,  8'd127, 8'd127, 8'd0,   1'b0},
        '{finish_show_pkg::NOTE_A, ACT_CLR,  8'd0,   8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_G, ACT_SET,  8'd127, 8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_G, ACT_NONE, 8'd0,   8'd127, 8'd0,   1'b0},
        '{finish_show_pkg::NOTE_G, ACT_CLR,  8'd0,   8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_F, ACT_SET,  8'd0,   8'd0,   8'd127, 1'b0},
        '{finish_show_pkg::NOTE_F, ACT_CLR,  8'd0,   8'd127, 8'd0,   1'b0},
        '{finish_show_pkg::NOTE_F, ACT_SET,  8'd127, 8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_F, ACT_CLR,  8'd0,   8'd0,   8'd127, 1'b0},
        '{finish_show_pkg::NOTE_E, ACT_SET,  8'd0,   8'd127, 8'd0,   1'b0},
        '{finish_show_pkg::NOTE_E, ACT_CLR,  8'd127, 8'd127, 8'd127, 1'b1},
        '{finish_show_pkg::NOTE_E, ACT_SET,  8'd0,   8'd127, 8'd127, 1'b0},
        '{finish_show_pkg::NOTE_E, ACT_CLR,  8'd0,   8'd127, 8'd0,   1'b0},
        '{finish_show_pkg::NOTE_D, ACT_SET,  8'd127, 8'd0,   8'd0,   1'b0},
        '{finish_show_pkg::NOTE_D, ACT_CLR,  8'd0,   8'd0,   8'd127, 1'b0},
        '{finish_show_pkg::NOTE_D, ACT_SET,  8'd127, 8'd0,   8'd127, 1'b0},
        '{finish_show_pkg::NOTE_D, ACT_CLR,  8'd127, 8'd127, 8'd127, 1'b0},
        '{finish_show_pkg::NOTE_C, ACT_SET,  8'd127, 8'd127, 8'd0,   1'b0},
        '{finish_show_pkg::NOTE_C, ACT_NONE, 8'd0,   8'd127, 8'd0,   1'b0},
        '{finish_show_pkg::NOTE_C, ACT_CLR,  8'd0,   8'd0,   8'd0,   1'b0}
    };

    logic                        clk;
    logic                        reset;
    logic                        show_en;
    logic                        red_up;
    logic                        red_down;
    logic                        green_up;
    logic                        green_down;
    logic                        blue_up;
    logic                        blue_down;
    logic                        sound_en;
    finish_show_pkg::note_t      note_sel;
    logic                        show_done;
    logic                        level_req;
    logic                        level_ack;
    logic                        sound_req;
    logic                        exp_sound;
    finish_show_pkg::note_t      exp_note;
    finish_show_pkg::rgb_level_t exp_level;
    int                          exp_done;
    int                          level_errors;
    int                          sound_errors;
    int                          done_errors;
    int                          seed;

    finish_show #(
        .TICK_DIV   (TICK_DIV),
        .RAMP_TICKS (RAMP_TICKS)
    ) u_dut (.*);

    show_checker u_checker (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic measure_levels(input finish_show_pkg::rgb_level_t lv, input int done_cnt);
        exp_level = lv;
        exp_done  = done_cnt;
        level_req = 1'b1;
        wait (level_ack);
        run_cycles(1);
        level_req = 1'b0;
        wait (!level_ack);
        run_cycles(1);
    endtask

    task automatic check_sound(input finish_show_pkg::note_t note);
        exp_note  = note;
        sound_req = 1'b1;
        run_cycles(1);
        sound_req = 1'b0;
    endtask

    // Straight ramp of one step, one level per tick
    function automatic logic [LEVEL_W-1:0] ramp_point(
        input logic [LEVEL_W-1:0] from,
        input logic [LEVEL_W-1:0] to,
        input int                 ticks
    );
        int delta;
        delta = (int'(to) - int'(from)) * ticks / RAMP_TICKS;
        ramp_point = LEVEL_W'(int'(from) + delta);
    endfunction

    task automatic play_step(input int n, input finish_show_pkg::rgb_level_t start_lv);
        row_t                        row;
        finish_show_pkg::rgb_level_t mid_lv;
        int                          split;
        row = SCRIPT_TAB[n % SCRIPT_LEN];
        if (row.action == ACT_SET) begin
            exp_sound = 1'b1;
        end else if (row.action == ACT_CLR) begin
            exp_sound = 1'b0;
        end
        show_en = 1'b1;
        run_cycles(TICK_DIV);           // Up to the first tick
        check_sound(row.note);
        if (row.pause) begin
            split = 16 + ($random(seed) & 255);
            run_cycles(split - TICK_DIV - 1);
            show_en = 1'b0;
            run_cycles($random(seed) & 63);
            mid_lv.red   = ramp_point(start_lv.red, row.red, split / TICK_DIV);
            mid_lv.green = ramp_point(start_lv.green, row.green, split / TICK_DIV);
            mid_lv.blue  = ramp_point(start_lv.blue, row.blue, split / TICK_DIV);
            measure_levels(mid_lv, n / SCRIPT_LEN);
            check_sound(row.note);
            show_en = 1'b1;
            run_cycles(STEP_CYCLES - split);
        end else begin
            run_cycles(STEP_CYCLES - TICK_DIV - 1);
        end
        show_en = 1'b0;
        measure_levels('{row.red, row.green, row.blue}, (n + 1) / SCRIPT_LEN);
        check_sound(row.note);          // Held while stopped
    endtask

    initial begin
        finish_show_pkg::rgb_level_t start_lv;
        seed      = 32'ha2c111d1;
        reset     = 1'b1;
        show_en   = 1'b0;
        level_req = 1'b0;
        sound_req = 1'b0;
        exp_sound = 1'b0;
        exp_note  = finish_show_pkg::NOTE_C;
        exp_level = '0;
        exp_done  = 0;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        measure_levels('0, 0);          // Dark and silent after reset
        check_sound(finish_show_pkg::NOTE_C);
        start_lv = '0;
        for (int n = 0; n <= SCRIPT_LEN; n++) begin  // Last pass replays step 1
            play_step(n, start_lv);
            start_lv = exp_level;
        end
        $display("Closing counts: %0d level errors, %0d sound errors, %0d done errors",
                 level_errors, sound_errors, done_errors);
        if (level_errors + sound_errors + done_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the show did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
